//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module alu (
  input  rv_pkg::alu_op_e     i_op,
  input  logic [`RV_XLEN-1:0] i_a,
  input  logic [`RV_XLEN-1:0] i_b,
  output logic [`RV_XLEN-1:0] o_result
);

  localparam int SHAMT_W = $clog2(`RV_XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;

  // shift amount from the low bits of b only
  assign shamt = i_b[SHAMT_W-1:0];

  assign lt_signed   = $signed(i_a) < $signed(i_b);
  assign lt_unsigned = i_a < i_b;

  always_comb begin
    case (i_op)
      rv_pkg::ALU_ADD:    o_result = i_a + i_b;
      rv_pkg::ALU_SUB:    o_result = i_a - i_b;
      rv_pkg::ALU_SLL:    o_result = i_a << shamt;
      rv_pkg::ALU_SLT: begin
        o_result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      end
      rv_pkg::ALU_SLTU: begin
        o_result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      end
      rv_pkg::ALU_XOR:    o_result = i_a ^ i_b;
      rv_pkg::ALU_SRL:    o_result = i_a >> shamt;
      // arithmetic shift keeps the sign bit
      rv_pkg::ALU_SRA:    o_result = $unsigned($signed(i_a) >>> shamt);
      rv_pkg::ALU_OR:     o_result = i_a | i_b;
      rv_pkg::ALU_AND:    o_result = i_a & i_b;
      // lui carries its upper immediate in b
      rv_pkg::ALU_PASS_B: o_result = i_b;
      default:            o_result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
rv_pkg.sv
wb_bus_if.sv
fetch_unit.sv
register_file.sv
alu.sv
decode_stage.sv
execute_stage.sv
rv_core.sv
tb_rv_core.sv

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module decode_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_pkg::stage_decode_t  i_decode,
  wb_bus_if.sink                 wb,
  output rv_pkg::stage_execute_t o_execute
);

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT = 7'b0100000;
  localparam logic [`RV_XLEN-1:0] INSN_ECALL = 32'h0000_0073;

  rv_pkg::opcode_e           opcode;
  logic [2:0]                funct3;
  logic [6:0]                funct7;
  logic [`RV_REG_ADDR_W-1:0] rs1;
  logic [`RV_REG_ADDR_W-1:0] rs2;
  logic [`RV_REG_ADDR_W-1:0] rd;
  logic [`RV_XLEN-1:0]       imm_i;
  logic [`RV_XLEN-1:0]       imm_u;
  logic [`RV_XLEN-1:0]       rs1_data;
  logic [`RV_XLEN-1:0]       rs2_data;
  rv_pkg::stage_execute_t    exe_next;
  logic                      illegal;

  assign opcode = rv_pkg::opcode_e'(i_decode.insn[6:0]);
  assign rd     = i_decode.insn[11:7];
  assign funct3 = i_decode.insn[14:12];
  assign rs1    = i_decode.insn[19:15];
  assign rs2    = i_decode.insn[24:20];
  assign funct7 = i_decode.insn[31:25];

  assign imm_i = {{(`RV_XLEN-12){i_decode.insn[31]}}, i_decode.insn[31:20]};
  assign imm_u = {i_decode.insn[31:12], 12'b0};

  register_file rf (
    .clk        (clk),
    .rst        (rst),
    .wb         (wb),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  always_comb begin
    illegal           = 1'b0;
    exe_next.pc       = i_decode.pc;
    exe_next.insn     = i_decode.insn;
    exe_next.status   = i_decode.status;
    exe_next.rs1      = rs1;
    exe_next.rs2      = rs2;
    exe_next.rs1_data = rs1_data;
    exe_next.rs2_data = rs2_data;
    exe_next.imm      = imm_i;
    exe_next.use_imm  = 1'b0;
    exe_next.alu_op   = rv_pkg::ALU_ADD;
    exe_next.rd       = rd;
    exe_next.we       = 1'b0;
    exe_next.halt     = 1'b0;
    case (opcode)
      rv_pkg::OP_REG_IMM: begin
        exe_next.use_imm = 1'b1;
        exe_next.we      = 1'b1;
        case (funct3)
          3'b000: exe_next.alu_op = rv_pkg::ALU_ADD;
          3'b010: exe_next.alu_op = rv_pkg::ALU_SLT;
          3'b011: exe_next.alu_op = rv_pkg::ALU_SLTU;
          3'b100: exe_next.alu_op = rv_pkg::ALU_XOR;
          3'b110: exe_next.alu_op = rv_pkg::ALU_OR;
          3'b111: exe_next.alu_op = rv_pkg::ALU_AND;
          3'b001: begin
            exe_next.alu_op = rv_pkg::ALU_SLL;
            illegal = (funct7 != F7_BASE);
          end
          default: begin
            // srli or srai, told apart by funct7
            exe_next.alu_op = (funct7 == F7_ALT) ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
          end
        endcase
      end
      rv_pkg::OP_REG_REG: begin
        exe_next.we = 1'b1;
        case ({funct7, funct3})
          {F7_BASE, 3'b000}: exe_next.alu_op = rv_pkg::ALU_ADD;
          {F7_ALT, 3'b000}:  exe_next.alu_op = rv_pkg::ALU_SUB;
          {F7_BASE, 3'b001}: exe_next.alu_op = rv_pkg::ALU_SLL;
          {F7_BASE, 3'b010}: exe_next.alu_op = rv_pkg::ALU_SLT;
          {F7_BASE, 3'b011}: exe_next.alu_op = rv_pkg::ALU_SLTU;
          {F7_BASE, 3'b100}: exe_next.alu_op = rv_pkg::ALU_XOR;
          {F7_BASE, 3'b101}: exe_next.alu_op = rv_pkg::ALU_SRL;
          {F7_ALT, 3'b101}:  exe_next.alu_op = rv_pkg::ALU_SRA;
          {F7_BASE, 3'b110}: exe_next.alu_op = rv_pkg::ALU_OR;
          {F7_BASE, 3'b111}: exe_next.alu_op = rv_pkg::ALU_AND;
          default:           illegal = 1'b1;
        endcase
      end
      rv_pkg::OP_LUI: begin
        exe_next.imm     = imm_u;
        exe_next.use_imm = 1'b1;
        exe_next.alu_op  = rv_pkg::ALU_PASS_B;
        exe_next.we      = 1'b1;
      end
      rv_pkg::OP_ENVIRON: begin
        // only plain ecall, every other system encoding is illegal
        exe_next.halt = (i_decode.insn == INSN_ECALL);
        illegal = (i_decode.insn != INSN_ECALL);
      end
      default: illegal = 1'b1;
    endcase

    // reset slots and illegal insns must not write or halt
    if (i_decode.status == rv_pkg::CYCLE_RESET) begin
      exe_next.we   = 1'b0;
      exe_next.halt = 1'b0;
    end else if (illegal) begin
      exe_next.status = rv_pkg::CYCLE_ILLEGAL;
      exe_next.we     = 1'b0;
      exe_next.halt   = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_execute        <= '0;
      o_execute.status <= rv_pkg::CYCLE_RESET;
    end else begin
      o_execute <= exe_next;
    end
  end

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module execute_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_pkg::stage_execute_t i_execute,
  wb_bus_if.source               wb
);

  logic                fwd_rs1;
  logic                fwd_rs2;
  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] rs2_val;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_result;

  // distance one hazards, the insn just ahead is sitting on the bus
  assign fwd_rs1 = wb.we && (wb.rd != '0) && (wb.rd == i_execute.rs1);
  assign fwd_rs2 = wb.we && (wb.rd != '0) && (wb.rd == i_execute.rs2);

  assign op_a    = fwd_rs1 ? wb.result : i_execute.rs1_data;
  assign rs2_val = fwd_rs2 ? wb.result : i_execute.rs2_data;

  // immediate forms ignore rs2 entirely
  assign op_b = i_execute.use_imm ? i_execute.imm : rs2_val;

  alu u_alu (
    .i_op     (i_execute.alu_op),
    .i_a      (op_a),
    .i_b      (op_b),
    .o_result (alu_result)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      wb.we       <= 1'b0;
      wb.rd       <= '0;
      wb.result   <= '0;
      wb.pc       <= '0;
      wb.insn     <= '0;
      wb.status   <= rv_pkg::CYCLE_RESET;
      wb.is_ecall <= 1'b0;
    end else begin
      wb.we       <= i_execute.we;
      wb.rd       <= i_execute.rd;
      wb.result   <= alu_result;
      wb.pc       <= i_execute.pc;
      wb.insn     <= i_execute.insn;
      wb.status   <= i_execute.status;
      wb.is_ecall <= i_execute.halt;
    end
  end

endmodule

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module fetch_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`RV_XLEN-1:0]   i_insn,
  output logic [`RV_XLEN-1:0]   o_pc,
  output rv_pkg::stage_decode_t o_decode
);

  logic [`RV_XLEN-1:0] pc_q;

  // no branches, so the pc only ever steps forward
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= `RV_RESET_PC;
    end else begin
      pc_q <= pc_q + `RV_PC_STEP;
    end
  end

  assign o_pc = pc_q;

  // insn for pc_q arrives on the falling edge
  always_ff @(posedge clk) begin
    if (rst) begin
      o_decode.pc     <= '0;
      o_decode.insn   <= '0;
      o_decode.status <= rv_pkg::CYCLE_RESET;
    end else begin
      o_decode.pc     <= pc_q;
      o_decode.insn   <= i_insn;
      o_decode.status <= rv_pkg::CYCLE_NO_STALL;
    end
  end

endmodule

`default_nettype wire

//--- register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module register_file (
  input  logic                      clk,
  input  logic                      rst,
  wb_bus_if.sink                    wb,
  input  logic [`RV_REG_ADDR_W-1:0] i_rs1,
  input  logic [`RV_REG_ADDR_W-1:0] i_rs2,
  output logic [`RV_XLEN-1:0]       o_rs1_data,
  output logic [`RV_XLEN-1:0]       o_rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

  // x0 is never written, so it stays at its reset value
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we && (wb.rd != '0)) begin
      regs[wb.rd] <= wb.result;
    end
  end

  // write-through, the pending writeback wins over the array
  function automatic logic [`RV_XLEN-1:0] read_port(
    input logic [`RV_REG_ADDR_W-1:0] idx
  );
    if (wb.we && (idx != '0) && (idx == wb.rd)) begin
      return wb.result;
    end
    return regs[idx];
  endfunction

  assign o_rs1_data = read_port(i_rs1);
  assign o_rs2_data = read_port(i_rs2);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_rv_core -f build.f -o tb_rv_core

out=$(./obj_dir/tb_rv_core)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Everything OK'; then
  exit 0
fi
exit 1

//--- rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module rv_core (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`RV_XLEN-1:0]   i_insn,
  output logic [`RV_XLEN-1:0]   o_pc,
  output logic                  o_halt,
  output logic [`RV_XLEN-1:0]   o_trace_pc,
  output logic [`RV_XLEN-1:0]   o_trace_insn,
  output rv_pkg::cycle_status_e o_trace_status,
  output logic                  o_trace_we,
  output logic [`RV_XLEN-1:0]   o_trace_data
);

  rv_pkg::stage_decode_t  decode_state;
  rv_pkg::stage_execute_t execute_state;

  wb_bus_if wb ();

  fetch_unit u_fetch (
    .clk      (clk),
    .rst      (rst),
    .i_insn   (i_insn),
    .o_pc     (o_pc),
    .o_decode (decode_state)
  );

  decode_stage u_decode (
    .clk       (clk),
    .rst       (rst),
    .i_decode  (decode_state),
    .wb        (wb.sink),
    .o_execute (execute_state)
  );

  execute_stage u_execute (
    .clk       (clk),
    .rst       (rst),
    .i_execute (execute_state),
    .wb        (wb.source)
  );

  // trace shows whatever sits in writeback
  assign o_halt         = wb.is_ecall;
  assign o_trace_pc     = wb.pc;
  assign o_trace_insn   = wb.insn;
  assign o_trace_status = wb.status;
  assign o_trace_we     = wb.we;
  assign o_trace_data   = wb.result;

endmodule

`default_nettype wire

//--- rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// register and instruction width
`define RV_XLEN 32

// architectural register count
`define RV_REG_COUNT 32

// bits needed for a register index
`define RV_REG_ADDR_W 5

// first fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// bytes per instruction
`define RV_PC_STEP 32'd4

`endif

//--- rv_pkg.sv
`default_nettype none

`include "rv_params.svh"

package rv_pkg;

  // major opcodes the core understands
  typedef enum logic [6:0] {
    OP_REG_IMM = 7'b0010011,
    OP_REG_REG = 7'b0110011,
    OP_LUI     = 7'b0110111,
    OP_ENVIRON = 7'b1110011
  } opcode_e;

  // alu operations, pass_b serves lui
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // what a pipeline slot holds
  typedef enum logic [1:0] {
    CYCLE_RESET    = 2'd0,
    CYCLE_NO_STALL = 2'd1,
    CYCLE_ILLEGAL  = 2'd2
  } cycle_status_e;

  // state at the start of decode
  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] insn;
    cycle_status_e       status;
  } stage_decode_t;

  // state at the start of execute
  typedef struct packed {
    logic [`RV_XLEN-1:0]       pc;
    logic [`RV_XLEN-1:0]       insn;
    cycle_status_e             status;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_XLEN-1:0]       rs1_data;
    logic [`RV_XLEN-1:0]       rs2_data;
    logic [`RV_XLEN-1:0]       imm;
    logic                      use_imm;
    alu_op_e                   alu_op;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic                      we;
    logic                      halt;
  } stage_execute_t;

endpackage

`default_nettype wire

//--- tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module tb_rv_core;

  localparam int PROG_LEN = 200;
  localparam int MAX_CYCLES = 400;

  logic                  clk;
  logic                  rst;
  logic [`RV_XLEN-1:0]   i_insn;
  logic [`RV_XLEN-1:0]   o_pc;
  logic                  o_halt;
  logic [`RV_XLEN-1:0]   o_trace_pc;
  logic [`RV_XLEN-1:0]   o_trace_insn;
  rv_pkg::cycle_status_e o_trace_status;
  logic                  o_trace_we;
  logic [`RV_XLEN-1:0]   o_trace_data;

  logic [31:0]           lfsr;
  logic [31:0]           prog [0:PROG_LEN];
  logic                  exp_we [0:PROG_LEN];
  logic                  exp_halt [0:PROG_LEN];
  logic [31:0]           exp_data [0:PROG_LEN];
  rv_pkg::cycle_status_e exp_status [0:PROG_LEN];
  int                    exp_test [0:PROG_LEN];
  int                    driven_at [0:PROG_LEN];
  int                    errs [1:6];
  int                    checks [1:6];

  rv_core UUT (
    .clk            (clk),
    .rst            (rst),
    .i_insn         (i_insn),
    .o_pc           (o_pc),
    .o_halt         (o_halt),
    .o_trace_pc     (o_trace_pc),
    .o_trace_insn   (o_trace_insn),
    .o_trace_status (o_trace_status),
    .o_trace_we     (o_trace_we),
    .o_trace_data   (o_trace_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // half the picks stay in x0..x7 so hazards come often
  function automatic logic [4:0] pick_reg();
    return take_bits(1) != 0 ? 5'(take_bits(3)) : 5'(take_bits(5));
  endfunction

  function automatic logic [31:0] random_insn();
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [3:0]  sel;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    rd  = pick_reg();
    rs1 = pick_reg();
    rs2 = pick_reg();
    if (take_bits(8) < 13) begin
      opc = 7'(take_bits(7));
      // flipping bit 3 never lands on a supported opcode
      if (opc == 7'h13 || opc == 7'h33 || opc == 7'h37 || opc == 7'h73) begin
        opc = opc ^ 7'h08;
      end
      return {25'(take_bits(25)), opc};
    end
    sel = 4'(take_bits(4));
    if (sel < 4'd7) begin
      f3  = 3'(take_bits(3));
      imm = 12'(take_bits(12));
      if (f3 == 3'd1) imm[11:5] = 7'h00;
      if (f3 == 3'd5) imm[11:5] = (take_bits(1) != 0) ? 7'h20 : 7'h00;
      return {imm, rs1, f3, rd, 7'h13};
    end
    if (sel < 4'd14) begin
      sel = 4'(take_bits(4));
      if (sel > 4'd9) sel = sel - 4'd6;
      case (sel)
        4'd0, 4'd1: f3 = 3'd0;
        4'd2: f3 = 3'd1;
        4'd3: f3 = 3'd2;
        4'd4: f3 = 3'd3;
        4'd5: f3 = 3'd4;
        4'd6, 4'd7: f3 = 3'd5;
        4'd8: f3 = 3'd6;
        default: f3 = 3'd7;
      endcase
      f7 = (sel == 4'd1 || sel == 4'd7) ? 7'h20 : 7'h00;
      return {f7, rs2, rs1, f3, rd, 7'h33};
    end
    return {20'(take_bits(20)), rd, 7'h37};
  endfunction

  // reference alu where alt selects sub or sra
  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << sh;
      3'd2: return {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
      3'd3: return {31'd0, a < b};
      3'd4: return a ^ b;
      3'd5: return (a >> sh) | ((alt && a[31]) ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic model_run();
    logic [31:0] regs [32];
    logic [31:0] insn;
    logic [31:0] res;
    logic [31:0] shadow;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        ill;
    logic        reads_rs1;
    logic        reads_rs2;
    for (int r = 0; r < 32; r++) regs[r] = '0;
    // regs named as rd by an illegal insn until a legal write
    shadow = '0;
    for (int i = 0; i <= PROG_LEN; i++) begin
      insn = prog[i];
      rd = insn[11:7];
      rs1 = insn[19:15];
      rs2 = insn[24:20];
      res = '0;
      ill = 1'b0;
      reads_rs1 = 1'b0;
      reads_rs2 = 1'b0;
      exp_we[i] = 1'b0;
      exp_halt[i] = 1'b0;
      case (insn[6:0])
        7'h13: begin
          exp_we[i] = 1'b1;
          reads_rs1 = 1'b1;
          if (insn[14:12] == 3'd1 && insn[31:25] != 7'h00) ill = 1'b1;
          if (insn[14:12] == 3'd5 && insn[31:25] != 7'h00 && insn[31:25] != 7'h20) ill = 1'b1;
          res = alu_model(insn[14:12], insn[14:12] == 3'd5 && insn[30], regs[rs1],
                          {{20{insn[31]}}, insn[31:20]});
        end
        7'h33: begin
          exp_we[i] = 1'b1;
          reads_rs1 = 1'b1;
          reads_rs2 = 1'b1;
          if (insn[31:25] == 7'h20) ill = insn[14:12] != 3'd0 && insn[14:12] != 3'd5;
          else if (insn[31:25] != 7'h00) ill = 1'b1;
          res = alu_model(insn[14:12], insn[30], regs[rs1], regs[rs2]);
        end
        7'h37: begin
          exp_we[i] = 1'b1;
          res = {insn[31:12], 12'h000};
        end
        7'h73: begin
          if (insn == 32'h0000_0073) exp_halt[i] = 1'b1;
          else ill = 1'b1;
        end
        default: ill = 1'b1;
      endcase
      exp_data[i] = res;
      exp_status[i] = rv_pkg::CYCLE_NO_STALL;
      exp_test[i] = 3;
      if (ill) begin
        exp_we[i] = 1'b0;
        exp_halt[i] = 1'b0;
        exp_status[i] = rv_pkg::CYCLE_ILLEGAL;
        exp_test[i] = 5;
        if (rd != 5'd0) shadow[rd] = 1'b1;
      end else if (exp_halt[i]) begin
        exp_test[i] = 6;
      end else if ((reads_rs1 && rs1 == 5'd0) || (reads_rs2 && rs2 == 5'd0) || rd == 5'd0) begin
        exp_test[i] = 4;
      end else if ((reads_rs1 && shadow[rs1]) || (reads_rs2 && shadow[rs2])) begin
        exp_test[i] = 5;
      end
      if (exp_we[i] && rd != 5'd0) begin
        regs[rd] = res;
        shadow[rd] = 1'b0;
      end
    end
  endtask

  task automatic report_value(input int test, input string name,
                              input logic [31:0] got, input logic [31:0] exp);
    errs[test]++;
    $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
  endtask

  task automatic report_text(input int test, input string msg);
    errs[test]++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  // instruction memory that returns a nop past the program
  task automatic drive_fetch(input int cycle);
    int idx;
    idx = int'(o_pc >> 2);
    if (o_pc[1:0] == 2'b00 && idx <= PROG_LEN) begin
      i_insn = prog[idx];
      driven_at[idx] = cycle;
    end else begin
      i_insn = 32'h0000_0013;
    end
  endtask

  task automatic check_trace(input int idx, input int cycle);
    int t;
    t = exp_test[idx];
    checks[2]++;
    if (o_trace_pc !== 32'(idx * 4)) report_value(2, "o_trace_pc", o_trace_pc, 32'(idx * 4));
    if (o_trace_insn !== prog[idx]) report_value(2, "o_trace_insn", o_trace_insn, prog[idx]);
    if (cycle - driven_at[idx] != 3) begin
      report_text(2, $sformatf("insn %0d reached writeback %0d cycles after its fetch",
                               idx, cycle - driven_at[idx]));
    end
    checks[t]++;
    if (o_trace_status !== exp_status[idx]) begin
      report_value(t, "o_trace_status", 32'(o_trace_status), 32'(exp_status[idx]));
    end
    if (o_trace_we !== exp_we[idx]) begin
      report_value(t, "o_trace_we", 32'(o_trace_we), 32'(exp_we[idx]));
    end
    if (exp_we[idx] && o_trace_data !== exp_data[idx]) begin
      report_value(t, "o_trace_data", o_trace_data, exp_data[idx]);
    end
    checks[6]++;
    if (o_halt !== exp_halt[idx]) report_value(6, "o_halt", 32'(o_halt), 32'(exp_halt[idx]));
  endtask

  function automatic string test_name(input int t);
    case (t)
      1: return "reset and pc stepping";
      2: return "trace order and latency";
      3: return "alu results";
      4: return "x0 reads and writes";
      5: return "illegal instructions";
      default: return "halt on ecall";
    endcase
  endfunction

  initial begin
    int          cycle;
    int          exp_idx;
    int          total_err;
    int          total_chk;
    logic        done;
    rst = 1'b1;
    i_insn = 32'h0000_0013;
    lfsr = 32'h1569;
    for (int i = 0; i < PROG_LEN; i++) prog[i] = random_insn();
    prog[PROG_LEN] = 32'h0000_0073;
    model_run();
    for (int t = 1; t <= 6; t++) begin
      errs[t] = 0;
      checks[t] = 0;
    end
    for (int i = 0; i <= PROG_LEN; i++) driven_at[i] = -100;

    repeat (8) begin
      @(negedge clk);
      checks[1]++;
      if (o_pc !== 32'h0) report_value(1, "o_pc", o_pc, 32'h0);
      if (o_halt !== 1'b0) report_value(1, "o_halt", 32'(o_halt), 32'h0);
      if (o_trace_we !== 1'b0) report_value(1, "o_trace_we", 32'(o_trace_we), 32'h0);
      if (o_trace_data !== 32'h0) report_value(1, "o_trace_data", o_trace_data, 32'h0);
      if (o_trace_pc !== 32'h0) report_value(1, "o_trace_pc", o_trace_pc, 32'h0);
      if (o_trace_insn !== 32'h0) report_value(1, "o_trace_insn", o_trace_insn, 32'h0);
      if (o_trace_status !== rv_pkg::CYCLE_RESET) begin
        report_value(1, "o_trace_status", 32'(o_trace_status), 32'(rv_pkg::CYCLE_RESET));
      end
    end
    rst = 1'b0;
    cycle = 0;
    drive_fetch(cycle);

    exp_idx = 0;
    done = 1'b0;
    while (!done && cycle < MAX_CYCLES) begin
      @(negedge clk);
      cycle++;
      checks[1]++;
      if (o_pc !== 32'(cycle * 4)) report_value(1, "o_pc", o_pc, 32'(cycle * 4));
      if (o_trace_status === rv_pkg::CYCLE_RESET) begin
        checks[6]++;
        if (o_halt !== 1'b0) report_value(6, "o_halt", 32'(o_halt), 32'h0);
        if (exp_idx != 0) report_text(2, "a reset slot reached writeback mid program");
      end else begin
        check_trace(exp_idx, cycle);
        if (exp_idx == PROG_LEN) done = 1'b1;
        else exp_idx++;
      end
      drive_fetch(cycle);
    end
    if (!done) begin
      report_text(6, $sformatf("ecall did not reach writeback within %0d cycles", MAX_CYCLES));
    end

    total_err = 0;
    total_chk = 0;
    for (int t = 1; t <= 6; t++) begin
      $display("test %0d %s: %0d checks, %0d errors", t, test_name(t), checks[t], errs[t]);
      total_err += errs[t];
      total_chk += checks[t];
    end
    $display("all tests: %0d checks, %0d errors", total_chk, total_err);
    if (total_err == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- wb_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

// one instruction per cycle, levels only
interface wb_bus_if;
  logic                      we;
  logic [`RV_REG_ADDR_W-1:0] rd;
  logic [`RV_XLEN-1:0]       result;
  logic [`RV_XLEN-1:0]       pc;
  logic [`RV_XLEN-1:0]       insn;
  rv_pkg::cycle_status_e     status;
  logic                      is_ecall;

  // driven by the execute register
  modport source (output we, rd, result, pc, insn, status, is_ecall);

  // register file and top level trace
  modport sink (input we, rd, result, pc, insn, status, is_ecall);
endinterface

`default_nettype wire
